// File: src/pipe_pkg.sv
package pipe_pkg;

	// Datapath and storage sizes
	localparam int XLEN = 32;
	localparam int REG_W = 5;
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW = 6;

	// Major opcodes of the supported subset
	localparam logic [6:0] OP_R = 7'h33;
	localparam logic [6:0] OP_I = 7'h13;
	localparam logic [6:0] OP_LUI = 7'h37;
	localparam logic [6:0] OP_LOAD = 7'h03;
	localparam logic [6:0] OP_STORE = 7'h23;

	// Result source of an instruction
	localparam logic [2:0] SEL_ALU = 3'd0;
	localparam logic [2:0] SEL_MEM = 3'd3;

	// Immediate formats, U leaves rs1 unused
	localparam logic [2:0] IMM_I = 3'd0;
	localparam logic [2:0] IMM_S = 3'd1;
	localparam logic [2:0] IMM_U = 3'd2;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		PASS_B
	} alu_op_e;

	typedef struct packed {
		logic [6:0] opcode;
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic [REG_W-1:0] rd;
		logic wr_en;
		// Operand A comes from rs1
		logic sel_opA;
		// Operand B comes from the immediate
		logic sel_opB;
		logic is_stype;
		logic [2:0] imm_select;
		logic [2:0] sel_data;
		alu_op_e alu_op;
		logic mem_we;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] imm;
	} id_exe_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] store_data;
	} exe_mem_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [XLEN-1:0] result;
	} mem_wb_t;

	typedef struct packed {
		logic exe_to_id_a;
		logic exe_to_id_b;
		logic mem_to_id_a;
		logic mem_to_id_b;
		logic wb_to_id_a;
		logic wb_to_id_b;
		logic mem_to_exe_a;
		logic mem_to_exe_b;
		logic wb_to_exe_a;
		logic wb_to_exe_b;
	} fwd_t;

	typedef struct packed {
		logic [REG_W-1:0] rd;
		logic wr_en;
		logic is_store;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] value;
	} retire_t;

endpackage

// File: src/forwarding_unit.sv
module forwarding_unit (
	input  pipe_pkg::ctrl_t id_ctrl,
	input  pipe_pkg::ctrl_t exe_ctrl,
	input  logic exe_valid,
	input  pipe_pkg::ctrl_t mem_ctrl,
	input  logic mem_valid,
	input  pipe_pkg::ctrl_t wb_ctrl,
	input  logic wb_valid,
	output pipe_pkg::fwd_t fwd
);

	// Source register matches a live producer, x0 never forwards
	function automatic logic hit(input logic [pipe_pkg::REG_W-1:0] rs,
		input pipe_pkg::ctrl_t prod, input logic prod_valid);
		return prod_valid && prod.wr_en && (rs == prod.rd) && (rs != '0);
	endfunction

	// Everything except LUI reads rs1
	function automatic logic uses_a(input pipe_pkg::ctrl_t c);
		return c.sel_opA && (c.imm_select != pipe_pkg::IMM_U);
	endfunction

	// rs2 is read by R-type as operand B and by stores as data
	function automatic logic uses_b(input pipe_pkg::ctrl_t c);
		return (c.opcode == pipe_pkg::OP_R) || c.is_stype;
	endfunction

	logic id_use_a;
	logic id_use_b;
	logic exe_use_a;
	logic exe_use_b;
	logic exe_is_load;
	logic mem_is_load;
	logic wb_is_load;
	logic mem_hit_exe_a;
	logic mem_hit_exe_b;

	assign id_use_a = uses_a(id_ctrl);
	assign id_use_b = uses_b(id_ctrl);
	assign exe_use_a = uses_a(exe_ctrl);
	assign exe_use_b = uses_b(exe_ctrl);

	assign exe_is_load = exe_ctrl.sel_data == pipe_pkg::SEL_MEM;
	assign mem_is_load = mem_ctrl.sel_data == pipe_pkg::SEL_MEM;
	assign wb_is_load = wb_ctrl.sel_data == pipe_pkg::SEL_MEM;

	// ID operands
	// A load in EXE has no data yet, the MEM override picks it up next cycle
	assign fwd.exe_to_id_a = hit(id_ctrl.rs1, exe_ctrl, exe_valid) && !exe_is_load &&
		id_use_a;
	assign fwd.exe_to_id_b = hit(id_ctrl.rs2, exe_ctrl, exe_valid) && !exe_is_load &&
		id_use_b;

	// MEM holds only the address for a load, WB override covers it
	assign fwd.mem_to_id_a = hit(id_ctrl.rs1, mem_ctrl, mem_valid) && !mem_is_load &&
		id_use_a;
	assign fwd.mem_to_id_b = hit(id_ctrl.rs2, mem_ctrl, mem_valid) && !mem_is_load &&
		id_use_b;

	// WB result is final for every source
	assign fwd.wb_to_id_a = hit(id_ctrl.rs1, wb_ctrl, wb_valid) && id_use_a;
	assign fwd.wb_to_id_b = hit(id_ctrl.rs2, wb_ctrl, wb_valid) && id_use_b;

	// EXE operands, load data only
	// Any MEM-stage writer of the same register is younger than WB
	assign mem_hit_exe_a = hit(exe_ctrl.rs1, mem_ctrl, mem_valid) && exe_use_a;
	assign mem_hit_exe_b = hit(exe_ctrl.rs2, mem_ctrl, mem_valid) && exe_use_b;

	// Load directly ahead, data straight from the memory read port
	assign fwd.mem_to_exe_a = mem_hit_exe_a && mem_is_load;
	assign fwd.mem_to_exe_b = mem_hit_exe_b && mem_is_load;

	// Load two ahead, unless something younger rewrote the register
	assign fwd.wb_to_exe_a = hit(exe_ctrl.rs1, wb_ctrl, wb_valid) && wb_is_load &&
		exe_use_a && !mem_hit_exe_a;
	assign fwd.wb_to_exe_b = hit(exe_ctrl.rs2, wb_ctrl, wb_valid) && wb_is_load &&
		exe_use_b && !mem_hit_exe_b;

endmodule

// File: src/decoder.sv
module decoder (
	input  logic [31:0] instr,
	output pipe_pkg::ctrl_t ctrl,
	output logic [pipe_pkg::XLEN-1:0] imm
);

	logic [2:0] funct3;
	logic [6:0] funct7;

	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		// Nop unless the opcode says otherwise
		ctrl = '0;
		ctrl.opcode = instr[6:0];
		ctrl.rd = instr[11:7];
		ctrl.rs1 = instr[19:15];
		ctrl.rs2 = instr[24:20];
		ctrl.sel_opB = 1'b1;
		ctrl.imm_select = pipe_pkg::IMM_I;
		ctrl.sel_data = pipe_pkg::SEL_ALU;
		ctrl.alu_op = pipe_pkg::ADD;
		case (instr[6:0])
			pipe_pkg::OP_R: begin
				ctrl.sel_opA = 1'b1;
				ctrl.sel_opB = 1'b0;
				ctrl.wr_en = 1'b1;
				case (funct3)
					3'b000: ctrl.alu_op = funct7[5] ? pipe_pkg::SUB : pipe_pkg::ADD;
					3'b100: ctrl.alu_op = pipe_pkg::XOR;
					3'b110: ctrl.alu_op = pipe_pkg::OR;
					3'b111: ctrl.alu_op = pipe_pkg::AND;
					default: ctrl.wr_en = 1'b0;
				endcase
				// Only SUB may carry funct7 bit 5
				if (funct7 != 7'h00 && !(funct3 == 3'b000 && funct7 == 7'h20))
					ctrl.wr_en = 1'b0;
			end
			pipe_pkg::OP_I: begin
				// ADDI only
				ctrl.sel_opA = 1'b1;
				ctrl.wr_en = funct3 == 3'b000;
			end
			pipe_pkg::OP_LUI: begin
				ctrl.wr_en = 1'b1;
				ctrl.imm_select = pipe_pkg::IMM_U;
				ctrl.alu_op = pipe_pkg::PASS_B;
			end
			pipe_pkg::OP_LOAD: begin
				// LW, address from the ALU
				ctrl.sel_opA = 1'b1;
				ctrl.wr_en = funct3 == 3'b010;
				ctrl.sel_data = pipe_pkg::SEL_MEM;
			end
			pipe_pkg::OP_STORE: begin
				// SW
				ctrl.sel_opA = 1'b1;
				ctrl.is_stype = 1'b1;
				ctrl.imm_select = pipe_pkg::IMM_S;
				ctrl.mem_we = funct3 == 3'b010;
			end
			default: ;
		endcase
	end

	// Immediate assembly
	always_comb begin
		case (ctrl.imm_select)
			pipe_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			pipe_pkg::IMM_U: imm = {instr[31:12], 12'b0};
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

// File: src/reg_file.sv
module reg_file (
	input  logic clk,
	input  logic reset,
	input  logic [pipe_pkg::REG_W-1:0] rs1,
	input  logic [pipe_pkg::REG_W-1:0] rs2,
	input  logic we,
	input  logic [pipe_pkg::REG_W-1:0] rd,
	input  logic [pipe_pkg::XLEN-1:0] wdata,
	output logic [pipe_pkg::XLEN-1:0] rdata1,
	output logic [pipe_pkg::XLEN-1:0] rdata2
);

	// x0 has no storage
	logic [pipe_pkg::XLEN-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// Combinational reads, x0 reads zero
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: src/exe_stage.sv
module exe_stage (
	input  pipe_pkg::id_exe_t id_exe,
	input  pipe_pkg::fwd_t fwd,
	input  logic [pipe_pkg::XLEN-1:0] mem_rdata,
	input  logic [pipe_pkg::XLEN-1:0] wb_result,
	output logic [pipe_pkg::XLEN-1:0] result,
	output logic [pipe_pkg::XLEN-1:0] store_data
);

	logic [pipe_pkg::XLEN-1:0] op_a;
	logic [pipe_pkg::XLEN-1:0] rs2_val;
	logic [pipe_pkg::XLEN-1:0] op_b;

	// Load data overrides what ID captured
	// Memory port is the younger load
	assign op_a = fwd.mem_to_exe_a ? mem_rdata :
		fwd.wb_to_exe_a ? wb_result : id_exe.a;

	assign rs2_val = fwd.mem_to_exe_b ? mem_rdata :
		fwd.wb_to_exe_b ? wb_result : id_exe.store_data;

	// Immediate already sits in b for non R-type
	assign op_b = id_exe.ctrl.sel_opB ? id_exe.b : rs2_val;

	assign store_data = rs2_val;

	always_comb begin
		case (id_exe.ctrl.alu_op)
			pipe_pkg::ADD: result = op_a + op_b;
			pipe_pkg::SUB: result = op_a - op_b;
			pipe_pkg::AND: result = op_a & op_b;
			pipe_pkg::OR: result = op_a | op_b;
			pipe_pkg::XOR: result = op_a ^ op_b;
			// LUI, upper immediate as is
			pipe_pkg::PASS_B: result = id_exe.imm;
			default: result = op_a + op_b;
		endcase
	end

endmodule

// File: src/data_mem.sv
module data_mem (
	input  logic clk,
	input  logic reset,
	input  logic we,
	input  logic [pipe_pkg::DMEM_AW-1:0] addr,
	input  logic [pipe_pkg::XLEN-1:0] wdata,
	output logic [pipe_pkg::XLEN-1:0] rdata
);

	logic [pipe_pkg::XLEN-1:0] mem [0:pipe_pkg::DMEM_WORDS-1];

	// Word writes at the edge
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Read is combinational so a load can feed EXE in the same cycle
	assign rdata = mem[addr];

endmodule

// File: src/pipeline_top.sv
module pipeline_top (
	input  logic clk,
	input  logic reset,
	input  logic instr_valid,
	input  logic [31:0] instr,
	output logic retire_valid,
	output pipe_pkg::retire_t retire
);

	pipe_pkg::ctrl_t id_ctrl;
	logic [pipe_pkg::XLEN-1:0] id_imm;
	logic [pipe_pkg::XLEN-1:0] rdata1;
	logic [pipe_pkg::XLEN-1:0] rdata2;
	logic [pipe_pkg::XLEN-1:0] rs1_fwd;
	logic [pipe_pkg::XLEN-1:0] rs2_fwd;
	pipe_pkg::fwd_t fwd;

	pipe_pkg::id_exe_t id_exe_d;
	pipe_pkg::id_exe_t id_exe_q;
	logic [pipe_pkg::XLEN-1:0] exe_result;
	logic [pipe_pkg::XLEN-1:0] exe_store_data;

	pipe_pkg::exe_mem_t exe_mem_d;
	pipe_pkg::exe_mem_t exe_mem_q;
	logic [pipe_pkg::XLEN-1:0] mem_rdata;

	pipe_pkg::mem_wb_t mem_wb_d;
	pipe_pkg::mem_wb_t mem_wb_q;
	pipe_pkg::retire_t retire_d;

	// ID
	decoder dec0 (
		.instr(instr),
		.ctrl(id_ctrl),
		.imm(id_imm)
	);

	// Written from WB, same-cycle read covered by WB forwarding
	reg_file rf0 (
		.clk(clk),
		.reset(reset),
		.rs1(id_ctrl.rs1),
		.rs2(id_ctrl.rs2),
		.we(mem_wb_q.valid && mem_wb_q.ctrl.wr_en),
		.rd(mem_wb_q.ctrl.rd),
		.wdata(mem_wb_q.result),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	forwarding_unit fu0 (
		.id_ctrl(id_ctrl),
		.exe_ctrl(id_exe_q.ctrl),
		.exe_valid(id_exe_q.valid),
		.mem_ctrl(exe_mem_q.ctrl),
		.mem_valid(exe_mem_q.valid),
		.wb_ctrl(mem_wb_q.ctrl),
		.wb_valid(mem_wb_q.valid),
		.fwd(fwd)
	);

	// ID operand select, youngest producer first
	assign rs1_fwd = fwd.exe_to_id_a ? exe_result :
		fwd.mem_to_id_a ? exe_mem_q.alu_result :
		fwd.wb_to_id_a ? mem_wb_q.result : rdata1;

	assign rs2_fwd = fwd.exe_to_id_b ? exe_result :
		fwd.mem_to_id_b ? exe_mem_q.alu_result :
		fwd.wb_to_id_b ? mem_wb_q.result : rdata2;

	always_comb begin
		id_exe_d.valid = instr_valid;
		id_exe_d.ctrl = id_ctrl;
		// LUI ignores rs1
		id_exe_d.a = id_ctrl.sel_opA ? rs1_fwd : '0;
		id_exe_d.b = id_ctrl.sel_opB ? id_imm : rs2_fwd;
		id_exe_d.store_data = rs2_fwd;
		id_exe_d.imm = id_imm;
	end

	// EXE
	exe_stage exe0 (
		.id_exe(id_exe_q),
		.fwd(fwd),
		.mem_rdata(mem_rdata),
		.wb_result(mem_wb_q.result),
		.result(exe_result),
		.store_data(exe_store_data)
	);

	always_comb begin
		exe_mem_d.valid = id_exe_q.valid;
		exe_mem_d.ctrl = id_exe_q.ctrl;
		exe_mem_d.alu_result = exe_result;
		exe_mem_d.store_data = exe_store_data;
	end

	// MEM, word address from the ALU result
	data_mem dmem0 (
		.clk(clk),
		.reset(reset),
		.we(exe_mem_q.valid && exe_mem_q.ctrl.mem_we),
		.addr(exe_mem_q.alu_result[pipe_pkg::DMEM_AW+1:2]),
		.wdata(exe_mem_q.store_data),
		.rdata(mem_rdata)
	);

	always_comb begin
		mem_wb_d.valid = exe_mem_q.valid;
		mem_wb_d.ctrl = exe_mem_q.ctrl;
		// Final result, load data or ALU
		mem_wb_d.result = (exe_mem_q.ctrl.sel_data == pipe_pkg::SEL_MEM) ?
			mem_rdata : exe_mem_q.alu_result;
	end

	// Retire record built alongside MEM/WB
	always_comb begin
		retire_d.rd = exe_mem_q.ctrl.rd;
		retire_d.wr_en = exe_mem_q.ctrl.wr_en;
		retire_d.is_store = exe_mem_q.ctrl.mem_we;
		retire_d.addr = exe_mem_q.alu_result;
		retire_d.value = exe_mem_q.ctrl.mem_we ? exe_mem_q.store_data : mem_wb_d.result;
	end

	// Stage registers, only valid bits cleared
	always_ff @(posedge clk) begin
		id_exe_q <= id_exe_d;
		exe_mem_q <= exe_mem_d;
		mem_wb_q <= mem_wb_d;
		retire <= retire_d;
		if (reset) begin
			id_exe_q.valid <= 1'b0;
			exe_mem_q.valid <= 1'b0;
			mem_wb_q.valid <= 1'b0;
		end
	end

	assign retire_valid = mem_wb_q.valid;

endmodule

// File: dv/iss_model.svh
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

// Architectural state, x0 never written
logic [pipe_pkg::XLEN-1:0] model_regs [0:31];
logic [pipe_pkg::XLEN-1:0] model_mem [0:pipe_pkg::DMEM_WORDS-1];

task automatic model_reset();
	for (int i = 0; i < 32; i++)
		model_regs[i] = '0;
	for (int i = 0; i < pipe_pkg::DMEM_WORDS; i++)
		model_mem[i] = '0;
endtask

// One instruction in program order, returns its retire record
task automatic model_exec(input logic [31:0] ins, output pipe_pkg::retire_t exp);
	logic [4:0] rd;
	logic [pipe_pkg::XLEN-1:0] src1;
	logic [pipe_pkg::XLEN-1:0] src2;
	logic [pipe_pkg::XLEN-1:0] imm_i;
	logic [pipe_pkg::XLEN-1:0] imm_s;
	rd = ins[11:7];
	src1 = model_regs[ins[19:15]];
	src2 = model_regs[ins[24:20]];
	imm_i = {{20{ins[31]}}, ins[31:20]};
	imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	exp = '0;
	// rd field is reported even for stores
	exp.rd = rd;
	case (ins[6:0])
		pipe_pkg::OP_R: begin
			exp.wr_en = 1'b1;
			case (ins[14:12])
				3'b000: exp.addr = ins[30] ? src1 - src2 : src1 + src2;
				3'b100: exp.addr = src1 ^ src2;
				3'b110: exp.addr = src1 | src2;
				default: exp.addr = src1 & src2;
			endcase
		end
		pipe_pkg::OP_I: begin
			exp.wr_en = 1'b1;
			exp.addr = src1 + imm_i;
		end
		pipe_pkg::OP_LUI: begin
			exp.wr_en = 1'b1;
			exp.addr = {ins[31:12], 12'h000};
		end
		pipe_pkg::OP_LOAD: begin
			exp.wr_en = 1'b1;
			exp.addr = src1 + imm_i;
		end
		default: begin
			exp.is_store = 1'b1;
			exp.addr = src1 + imm_s;
		end
	endcase
	// Word index only, memory aliases above 256 bytes
	if (ins[6:0] == pipe_pkg::OP_LOAD)
		exp.value = model_mem[exp.addr[pipe_pkg::DMEM_AW+1:2]];
	else if (exp.is_store)
		exp.value = src2;
	else
		exp.value = exp.addr;
	if (exp.is_store)
		model_mem[exp.addr[pipe_pkg::DMEM_AW+1:2]] = src2;
	if (exp.wr_en && rd != 5'd0)
		model_regs[rd] = exp.value;
endtask

`endif

// File: dv/pipeline_tb.sv
module pipeline_tb;

	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 8;
	// Slots per test, bubbles included
	localparam int SLOTS = 60;
	localparam int SLOTS_DUMP = 6;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 6 * SLOTS + SLOTS_DUMP + 7 * (DRAIN_CYCLES + 1);
	localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 20) * 100;

	logic clk;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic retire_valid;
	pipe_pkg::retire_t retire;

	logic [31:0] lfsr;
	logic [4:0] last_rd;
	pipe_pkg::retire_t exp_q[$];
	logic dump_q[$];
	logic [pipe_pkg::XLEN-1:0] dump_val_q[$];
	int errors;
	int checks;
	int sent;
	int retired;

	`include "iss_model.svh"

	pipeline_top dut0 (
		.clk(clk),
		.reset(reset),
		.instr_valid(instr_valid),
		.instr(instr),
		.retire_valid(retire_valid),
		.retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired before all tests finished");
		$display("sim failed");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// x0 to x3 only, keeps hazards dense
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = take_bits(2);
		return {3'b000, r[1:0]};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], pipe_pkg::OP_STORE};
	endfunction

	function automatic logic [31:0] gen_alu();
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		rd = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		r = take_bits(3);
		case (r[2:0])
			3'd0: return {7'h00, rs2, rs1, 3'b000, rd, pipe_pkg::OP_R};
			3'd1: return {7'h20, rs2, rs1, 3'b000, rd, pipe_pkg::OP_R};
			3'd2: return {7'h00, rs2, rs1, 3'b111, rd, pipe_pkg::OP_R};
			3'd3: return {7'h00, rs2, rs1, 3'b110, rd, pipe_pkg::OP_R};
			3'd4: return {7'h00, rs2, rs1, 3'b100, rd, pipe_pkg::OP_R};
			default: begin
				r = take_bits(12);
				return enc_i(r[11:0], rs1, 3'b000, rd, pipe_pkg::OP_I);
			end
		endcase
	endfunction

	// Eight low words, now and then off a register base
	function automatic logic [31:0] gen_mem(input logic store);
		logic [31:0] r;
		logic [4:0] base;
		logic [4:0] reg_b;
		r = take_bits(4);
		base = r[3] ? pick_reg() : 5'd0;
		reg_b = pick_reg();
		if (store)
			return enc_s({7'b0, r[2:0], 2'b00}, reg_b, base);
		return enc_i({7'b0, r[2:0], 2'b00}, base, 3'b010, reg_b, pipe_pkg::OP_LOAD);
	endfunction

	// rs1 bit positions carry a live destination
	function automatic logic [31:0] gen_lui(input logic [4:0] rs1_field);
		logic [31:0] r;
		logic [4:0] rd;
		r = take_bits(15);
		rd = pick_reg();
		return {r[14:3], rs1_field, r[2:0], rd, pipe_pkg::OP_LUI};
	endfunction

	task automatic check_retire(input pipe_pkg::retire_t got, input pipe_pkg::retire_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: retire = %h, expected %h", got, exp);
		end
	endtask

	task automatic check_reg_value(input logic [4:0] idx, input logic [pipe_pkg::XLEN-1:0] got,
		input logic [pipe_pkg::XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: x%0d = %h, expected %h", idx, got, exp);
		end
	endtask

	task automatic make_slot(input int test_id, input int i, output logic valid,
		output logic [31:0] ins, output logic dump);
		logic [31:0] r;
		logic [4:0] dreg;
		valid = 1'b1;
		dump = 1'b0;
		r = take_bits(2);
		dreg = 5'(i / 2 + 1);
		case (test_id)
			1: begin
				valid = r[1:0] != 2'b00;
				ins = gen_alu();
			end
			// Gaps of two and three cycles
			2: begin
				valid = (i % 5 == 0) || (i % 5 == 2);
				ins = gen_alu();
			end
			3: ins = (i % 2 == 0) ? gen_mem(1'b0) : gen_alu();
			4: ins = (i % 3 == 0) ? gen_mem(1'b0) : gen_alu();
			5: ins = (i % 2 == 0) ? gen_alu() : gen_lui(last_rd);
			6: ins = gen_mem(r[0]);
			default: begin
				// x1 to x3 parked in words 57 to 59, then loaded back
				dump = i % 2 == 1;
				if (dump)
					ins = enc_i(12'((56 + dreg) * 4), 5'd0, 3'b010, dreg, pipe_pkg::OP_LOAD);
				else
					ins = enc_s(12'((56 + dreg) * 4), dreg, 5'd0);
			end
		endcase
		last_rd = ins[11:7];
	endtask

	// Drive one slot and run the model on it
	task automatic send(input logic valid, input logic [31:0] ins, input logic dump);
		pipe_pkg::retire_t exp;
		logic [pipe_pkg::XLEN-1:0] reg_val;
		instr_valid = valid;
		instr = ins;
		if (valid) begin
			reg_val = model_regs[ins[11:7]];
			model_exec(ins, exp);
			exp_q.push_back(exp);
			dump_q.push_back(dump);
			dump_val_q.push_back(reg_val);
			sent++;
		end
	endtask

	task automatic run_test(input string name, input int test_id, input int slots);
		int err0;
		int sent0;
		int ret0;
		int waited;
		logic valid;
		logic dump;
		logic [31:0] ins;
		err0 = errors;
		sent0 = sent;
		ret0 = retired;
		for (int i = 0; i < slots; i++) begin
			@(negedge clk);
			make_slot(test_id, i, valid, ins, dump);
			send(valid, ins, dump);
		end
		@(negedge clk);
		instr_valid = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (retired - ret0 != sent - sent0) begin
			errors++;
			$display("%s retired only %0d of %0d instructions", name, retired - ret0,
				sent - sent0);
			exp_q.delete();
			dump_q.delete();
			dump_val_q.delete();
		end
		$display("%s: %0d sent, %0d retired, %0d errors", name, sent - sent0,
			retired - ret0, errors - err0);
	endtask

	// Retire monitor, outputs settle after the rising edge
	always @(negedge clk) begin
		logic dump;
		logic [pipe_pkg::XLEN-1:0] dump_val;
		if (!reset && retire_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Retire seen with no instruction outstanding");
			end else begin
				check_retire(retire, exp_q.pop_front());
				dump = dump_q.pop_front();
				dump_val = dump_val_q.pop_front();
				if (dump)
					check_reg_value(retire.rd, retire.value, dump_val);
				retired++;
			end
		end
	end

	initial begin
		lfsr = 32'h034277b9;
		last_rd = 5'd0;
		errors = 0;
		checks = 0;
		sent = 0;
		retired = 0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		model_reset();
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		run_test("alu back to back", 1, SLOTS);
		run_test("alu distance two and three", 2, SLOTS);
		// Stores fill the low words so the load tests see nonzero data
		run_test("store then load", 6, SLOTS);
		run_test("load then use", 3, SLOTS);
		run_test("load then use two later", 4, SLOTS);
		run_test("lui and x0", 5, SLOTS);
		run_test("register dump", 7, SLOTS_DUMP);
		$display("tests 7, instructions %0d, checks %0d, errors %0d", sent, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+dv
src/pipe_pkg.sv
src/forwarding_unit.sv
src/decoder.sv
src/reg_file.sv
src/exe_stage.sv
src/data_mem.sv
src/pipeline_top.sv
dv/pipeline_tb.sv

// File: Makefile
TOP = pipeline_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log; cat sim.log
	@grep -q "sim passed" sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
